// File: verilog/icache_cfg_pkg.sv
// cache geometry and register map for the instruction cache
// direct mapped, 64 sets of 16-byte lines, 32-bit byte addresses
// changing a width here moves the address split in every block
// the register map is word addressed over a 2-bit Wishbone address

package icache_cfg_pkg;

    // address split: | tag | index | offset |
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int OFFSET_W   = 4;
    localparam int LINE_WORDS = 4;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    // derived geometry
    localparam int SETS   = 1 << INDEX_W;
    localparam int WSEL_W = $clog2(LINE_WORDS);

    // register port, word offsets
    localparam int REG_ADR_W = 2;
    localparam logic [REG_ADR_W-1:0] REG_CTRL   = 2'd0;
    localparam logic [REG_ADR_W-1:0] REG_ACCESS = 2'd1;
    localparam logic [REG_ADR_W-1:0] REG_MISS   = 2'd2;
    localparam logic [REG_ADR_W-1:0] REG_HIT    = 2'd3;

    // REG_CTRL bit positions
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_INV_BIT = 1;

endpackage

// File: verilog/icache_types_pkg.sv
// shared types for the instruction cache datapath and controller
// widths come from icache_cfg_pkg, so that package compiles first
// a line keeps word 0 in its low bits

package icache_types_pkg;

    // byte address as seen on the fetch port
    typedef logic [icache_cfg_pkg::ADDR_W-1:0] addr_t;

    // one instruction word
    typedef logic [icache_cfg_pkg::WORD_W-1:0] word_t;

    // full cache line, word 0 at the bottom
    typedef logic [icache_cfg_pkg::LINE_WORDS*icache_cfg_pkg::WORD_W-1:0] line_t;

    // address fields
    typedef logic [icache_cfg_pkg::TAG_W-1:0]   tag_t;
    typedef logic [icache_cfg_pkg::INDEX_W-1:0] index_t;

    // performance event counter
    typedef logic [31:0] count_t;

    // fetch FSM
    //   IDLE   waits for a fetch, tag read launched on acceptance
    //   LOOKUP compares tag, then holds for the ready cycle
    //   REFILL waits on the memory response
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } ctrl_state_t;

endpackage

// File: verilog/icache_array_if.sv
// link between the fetch controller and the tag/data store
// reads are synchronous, data appears after the edge the index is seen
// a write stores tag and line and marks the set valid

`timescale 1ns/1ps

interface icache_array_if;

    // controller side
    icache_types_pkg::index_t index;
    logic                     we;
    icache_types_pkg::tag_t   wr_tag;
    icache_types_pkg::line_t  wr_line;

    // store side, registered read data
    icache_types_pkg::tag_t   rd_tag;
    logic                     rd_valid;
    icache_types_pkg::line_t  rd_line;

    modport ctrl (
        output index, we, wr_tag, wr_line,
        input  rd_tag, rd_valid, rd_line
    );

    modport store (
        input  index, we, wr_tag, wr_line,
        output rd_tag, rd_valid, rd_line
    );

endinterface

// File: verilog/icache_store.sv
// tag, valid and line storage for a direct-mapped cache
// flop arrays, one read and one write per cycle
// a read at the same edge as a write returns the old contents
// invalidate_i clears every valid bit in a single cycle

`timescale 1ns/1ps

module icache_store (
    input  logic              clk_i,
    input  logic              rst_ni,
    icache_array_if.store     arr_if,
    input  logic              invalidate_i
);

    icache_types_pkg::tag_t                  tags_q  [icache_cfg_pkg::SETS];
    icache_types_pkg::line_t                 lines_q [icache_cfg_pkg::SETS];
    logic [icache_cfg_pkg::SETS-1:0]         valid_q;

    // valid bits are control state, cleared on reset and on invalidate
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q         <= '0;
            arr_if.rd_valid <= 1'b0;
        end else begin
            arr_if.rd_valid <= valid_q[arr_if.index];
            if (invalidate_i) begin
                valid_q <= '0;
            end else if (arr_if.we) begin
                valid_q[arr_if.index] <= 1'b1;
            end
        end
    end

    // tag and line contents
    always_ff @(posedge clk_i) begin
        arr_if.rd_tag  <= tags_q[arr_if.index];
        arr_if.rd_line <= lines_q[arr_if.index];
        if (arr_if.we) begin
            tags_q[arr_if.index]  <= arr_if.wr_tag;
            lines_q[arr_if.index] <= arr_if.wr_line;
        end
    end

    // controller only invalidates from IDLE, refill writes only from REFILL
    a_no_write_on_inv : assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(arr_if.we && invalidate_i)
    );

endmodule

// File: verilog/icache_controller.sv
// fetch FSM for the direct-mapped instruction cache
// hit answers 2 cycles after acceptance with a one-cycle ready pulse
// a miss refills a whole line and answers from the refill word
// with cache_en_i low every fetch refills and the store is not written
// invalidate requests are taken only in IDLE while fetches wait

`timescale 1ns/1ps

module icache_controller (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // CPU fetch port
    input  logic                     cpu_valid_i,
    input  icache_types_pkg::addr_t  cpu_addr_i,
    output logic                     cpu_ready_o,
    output icache_types_pkg::word_t  cpu_data_o,
    // memory refill port
    output logic                     mem_req_o,
    output icache_types_pkg::addr_t  mem_addr_o,
    input  logic                     mem_ready_i,
    input  icache_types_pkg::line_t  mem_line_i,
    // store
    icache_array_if.ctrl             arr_if,
    // register block
    input  logic                     cache_en_i,
    input  logic                     inv_req_i,
    output logic                     inv_ack_o,
    output logic                     access_o,
    output logic                     miss_o
);

    icache_types_pkg::ctrl_state_t state_q, state_d;
    icache_types_pkg::addr_t       req_addr_q;
    icache_types_pkg::word_t       data_q;
    icache_types_pkg::tag_t        req_tag;
    logic [icache_cfg_pkg::WSEL_W-1:0] req_word;
    logic ready_q;
    logic fill_q;
    logic accept;
    logic hit;
    logic compare;
    logic refill_done;

    // pick one word out of a line
    function automatic icache_types_pkg::word_t pick_word(
        input icache_types_pkg::line_t          line,
        input logic [icache_cfg_pkg::WSEL_W-1:0] sel
    );
        pick_word = line[int'(sel) * icache_cfg_pkg::WORD_W +: icache_cfg_pkg::WORD_W];
    endfunction

    // fields of the held request
    assign req_tag  = req_addr_q[icache_cfg_pkg::ADDR_W-1 -: icache_cfg_pkg::TAG_W];
    assign req_word = req_addr_q[icache_cfg_pkg::OFFSET_W-1 -: icache_cfg_pkg::WSEL_W];

    // pending invalidate blocks new fetches so no stale tag gets read
    assign accept    = (state_q == icache_types_pkg::IDLE) && cpu_valid_i && !inv_req_i;
    assign inv_ack_o = (state_q == icache_types_pkg::IDLE) && inv_req_i;

    // compare only in the first LOOKUP cycle
    // later LOOKUP cycles forward the fill or raise ready
    assign compare     = (state_q == icache_types_pkg::LOOKUP) && !ready_q && !fill_q;
    assign hit         = cache_en_i && arr_if.rd_valid && (arr_if.rd_tag == req_tag);
    assign refill_done = (state_q == icache_types_pkg::REFILL) && mem_ready_i;

    // store port
    // in IDLE the read goes out straight from the CPU address
    assign arr_if.index = (state_q == icache_types_pkg::IDLE)
        ? cpu_addr_i[icache_cfg_pkg::OFFSET_W +: icache_cfg_pkg::INDEX_W]
        : req_addr_q[icache_cfg_pkg::OFFSET_W +: icache_cfg_pkg::INDEX_W];
    assign arr_if.we      = refill_done && cache_en_i;
    assign arr_if.wr_tag  = req_tag;
    assign arr_if.wr_line = mem_line_i;

    // line-aligned refill request
    assign mem_req_o  = (state_q == icache_types_pkg::REFILL);
    assign mem_addr_o = {req_addr_q[icache_cfg_pkg::ADDR_W-1:icache_cfg_pkg::OFFSET_W],
                         {icache_cfg_pkg::OFFSET_W{1'b0}}};

    // event pulses for the counters
    assign access_o = accept;
    assign miss_o   = compare && !hit;

    assign cpu_ready_o = ready_q;
    assign cpu_data_o  = data_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_types_pkg::IDLE: begin
                if (accept) begin
                    state_d = icache_types_pkg::LOOKUP;
                end
            end
            icache_types_pkg::LOOKUP: begin
                // ready cycle ends the fetch
                if (ready_q) begin
                    state_d = icache_types_pkg::IDLE;
                end else if (compare && !hit) begin
                    state_d = icache_types_pkg::REFILL;
                end
            end
            icache_types_pkg::REFILL: begin
                // slow memory just keeps us here
                if (mem_ready_i) begin
                    state_d = icache_types_pkg::LOOKUP;
                end
            end
            default: begin
                state_d = icache_types_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= icache_types_pkg::IDLE;
            ready_q <= 1'b0;
            fill_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (compare && hit) || fill_q;
            // marks the LOOKUP cycle right after a refill
            fill_q  <= refill_done;
        end
    end

    // request address and answer word
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_addr_q <= cpu_addr_i;
        end
        if (refill_done) begin
            data_q <= pick_word(mem_line_i, req_word);
        end else if (compare && hit) begin
            data_q <= pick_word(arr_if.rd_line, req_word);
        end
    end

    // refill address must not move while memory has not answered
    a_mem_addr_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_ready_i) |=> (mem_req_o && $stable(mem_addr_o))
    );

    // ready only ever leaves from LOOKUP
    a_no_ready_idle : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (state_q == icache_types_pkg::IDLE) |-> !cpu_ready_o
    );

endmodule

// File: verilog/icache_regs.sv
// Wishbone classic register block beside the cache controller
// ack follows cyc/stb by one cycle and waits for stb to drop before the next
// writes land on the edge that raises ack
// a write to the access or miss counter clears both counters
// the invalidate request stays up until the controller acks it

`timescale 1ns/1ps

module icache_regs (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Wishbone classic slave
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  logic [icache_cfg_pkg::REG_ADR_W-1:0] wb_adr_i,
    input  icache_types_pkg::word_t              wb_dat_i,
    output icache_types_pkg::word_t              wb_dat_o,
    output logic                                 wb_ack_o,
    // controller side
    input  logic                                 access_i,
    input  logic                                 miss_i,
    input  logic                                 inv_ack_i,
    output logic                                 cache_en_o,
    output logic                                 inv_req_o,
    output logic                                 invalidate_o
);

    icache_types_pkg::count_t access_q, miss_q, hit_cnt;
    icache_types_pkg::word_t  rd_data;
    logic ack_q;
    logic held_q;
    logic en_q;
    logic inv_q;
    logic wb_start;
    logic ctrl_wr;
    logic cnt_clr;

    // one transfer per stb assertion
    assign wb_start = wb_cyc_i && wb_stb_i && !ack_q && !held_q;
    assign ctrl_wr  = wb_start && wb_we_i && (wb_adr_i == icache_cfg_pkg::REG_CTRL);
    assign cnt_clr  = wb_start && wb_we_i &&
                      ((wb_adr_i == icache_cfg_pkg::REG_ACCESS) ||
                       (wb_adr_i == icache_cfg_pkg::REG_MISS));

    // hits are whatever accesses did not miss
    assign hit_cnt = access_q - miss_q;

    // store sees the invalidate in the cycle the controller takes it
    assign invalidate_o = inv_q && inv_ack_i;
    assign inv_req_o    = inv_q;
    assign cache_en_o   = en_q;
    assign wb_ack_o     = ack_q;

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            icache_cfg_pkg::REG_CTRL:   rd_data[icache_cfg_pkg::CTRL_EN_BIT] = en_q;
            icache_cfg_pkg::REG_ACCESS: rd_data = access_q;
            icache_cfg_pkg::REG_MISS:   rd_data = miss_q;
            default:                    rd_data = hit_cnt;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q    <= 1'b0;
            held_q   <= 1'b0;
            en_q     <= 1'b1;
            inv_q    <= 1'b0;
            access_q <= '0;
            miss_q   <= '0;
        end else begin
            ack_q  <= wb_start;
            // stays set after ack until the master lets go of stb
            held_q <= wb_cyc_i && wb_stb_i && (held_q || ack_q);
            if (ctrl_wr) begin
                en_q <= wb_dat_i[icache_cfg_pkg::CTRL_EN_BIT];
            end
            if (ctrl_wr && wb_dat_i[icache_cfg_pkg::CTRL_INV_BIT]) begin
                inv_q <= 1'b1;
            end else if (inv_ack_i) begin
                inv_q <= 1'b0;
            end
            // clear wins over a same-cycle event
            if (cnt_clr) begin
                access_q <= '0;
                miss_q   <= '0;
            end else begin
                access_q <= access_q + icache_types_pkg::count_t'(access_i);
                miss_q   <= miss_q + icache_types_pkg::count_t'(miss_i);
            end
        end
    end

    // read data captured together with ack
    always_ff @(posedge clk_i) begin
        if (wb_start) begin
            wb_dat_o <= rd_data;
        end
    end

    // master keeps stb up until it sees ack
    a_ack_needs_stb : assert property (
        @(posedge clk_i) disable iff (!rst_ni) wb_ack_o |-> wb_stb_i
    );

endmodule

// File: verilog/icache_top.sv
// direct-mapped instruction cache, 64 x 16-byte lines
// CPU fetch and memory refill use valid/ready style handshakes
// control and counters sit behind a Wishbone classic slave port
// after reset the cache is enabled and every line is invalid

`timescale 1ns/1ps

module icache_top (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // CPU fetch port
    input  logic                                 cpu_valid_i,
    input  icache_types_pkg::addr_t              cpu_addr_i,
    output logic                                 cpu_ready_o,
    output icache_types_pkg::word_t              cpu_data_o,
    // memory refill port
    output logic                                 mem_req_o,
    output icache_types_pkg::addr_t              mem_addr_o,
    input  logic                                 mem_ready_i,
    input  icache_types_pkg::line_t              mem_line_i,
    // Wishbone classic register port
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  logic [icache_cfg_pkg::REG_ADR_W-1:0] wb_adr_i,
    input  icache_types_pkg::word_t              wb_dat_i,
    output icache_types_pkg::word_t              wb_dat_o,
    output logic                                 wb_ack_o
);

    logic cache_en;
    logic inv_req;
    logic inv_ack;
    logic invalidate;
    logic access_ev;
    logic miss_ev;

    icache_array_if arr_if ();

    icache_store u_store (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .arr_if       (arr_if.store),
        .invalidate_i (invalidate)
    );

    icache_controller u_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cpu_valid_i (cpu_valid_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_ready_o (cpu_ready_o),
        .cpu_data_o  (cpu_data_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_ready_i (mem_ready_i),
        .mem_line_i  (mem_line_i),
        .arr_if      (arr_if.ctrl),
        .cache_en_i  (cache_en),
        .inv_req_i   (inv_req),
        .inv_ack_o   (inv_ack),
        .access_o    (access_ev),
        .miss_o      (miss_ev)
    );

    icache_regs u_regs (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .access_i     (access_ev),
        .miss_i       (miss_ev),
        .inv_ack_i    (inv_ack),
        .cache_en_o   (cache_en),
        .inv_req_o    (inv_req),
        .invalidate_o (invalidate)
    );

endmodule

// File: tb/tb_clock.sv
// free running testbench clock, 8 ns period
// starts low at time zero

`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    initial clk_o = 1'b0;

    // half period
    always #4 clk_o = ~clk_o;

endmodule

// File: tb/tb_icache.sv
// directed testbench for the instruction cache
// memory model answers 1 to 6 cycles after a request with a one-cycle ready
// line word i at address A holds (A + 4i) ^ 32'h5a5a0000
// every wait loop gives up after a fixed number of cycles

`timescale 1ns/1ps

module tb_icache;

    localparam int FETCH_LIMIT = 50;
    localparam int WB_LIMIT    = 20;

    logic clk;
    logic rst_n;
    logic cpu_valid;
    icache_types_pkg::addr_t cpu_addr;
    logic cpu_ready;
    icache_types_pkg::word_t cpu_data;
    logic mem_req;
    icache_types_pkg::addr_t mem_addr;
    logic mem_ready = 1'b0;
    icache_types_pkg::line_t mem_line = '0;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [icache_cfg_pkg::REG_ADR_W-1:0] wb_adr;
    icache_types_pkg::word_t wb_dat_w;
    icache_types_pkg::word_t wb_dat_r;
    logic wb_ack;

    int errors = 0;
    int checks = 0;
    // expected counter values since the last clear
    int n_access = 0;
    int n_miss = 0;
    int n_hit = 0;
    // cycles left before the memory answers
    int mem_wait = 0;

    tb_clock u_clock (.clk_o(clk));

    icache_top uut (
        .clk_i(clk), .rst_ni(rst_n),
        .cpu_valid_i(cpu_valid), .cpu_addr_i(cpu_addr),
        .cpu_ready_o(cpu_ready), .cpu_data_o(cpu_data),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr),
        .mem_ready_i(mem_ready), .mem_line_i(mem_line),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
    );

    // next-level memory contents
    function automatic icache_types_pkg::word_t model_word(
        input icache_types_pkg::addr_t line_addr, input int i);
        return (line_addr + 32'(4 * i)) ^ 32'h5a5a0000;
    endfunction

    function automatic icache_types_pkg::line_t model_line(
        input icache_types_pkg::addr_t line_addr);
        icache_types_pkg::line_t line;
        line = '0;
        for (int i = 0; i < icache_cfg_pkg::LINE_WORDS; i++) begin
            line[i*32 +: 32] = model_word(line_addr, i);
        end
        return line;
    endfunction

    // memory model with random latency per request
    always @(posedge clk) begin
        mem_ready <= 1'b0;
        // skip the edge that already carries a response
        if (mem_req && !mem_ready) begin
            if (mem_wait == 0) begin
                mem_wait = 1 + int'($urandom % 6);
            end
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_ready <= 1'b1;
                mem_line  <= model_line(mem_addr);
            end
        end
    end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        errors++;
        $display("ERROR at %0t: %s got %h expected %h", $time, name, got, want);
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("TIMEOUT at %0t: no %s within the cycle limit", $time, what);
        finish_run();
    endtask

    // single Wishbone classic transfer that waits for ack and then drops stb
    task automatic wb_cycle(input logic we, input logic [1:0] adr,
                            input icache_types_pkg::word_t wdata,
                            output icache_types_pkg::word_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < WB_LIMIT);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        rdata = wb_dat_r;
        if (!wb_ack) begin
            timed_out("Wishbone ack");
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input icache_types_pkg::word_t data);
        icache_types_pkg::word_t unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output icache_types_pkg::word_t data);
        wb_cycle(1'b0, adr, '0, data);
    endtask

    // one fetch with checks on data, refill request and hit latency
    task automatic fetch(input icache_types_pkg::addr_t addr, input bit expect_miss);
        icache_types_pkg::addr_t line_addr;
        icache_types_pkg::word_t expected;
        int  edges;
        bit  saw_req;
        line_addr = {addr[31:4], 4'h0};
        expected  = model_word(line_addr, int'(addr[3:2]));
        edges     = 0;
        saw_req   = 1'b0;
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_addr  <= addr;
        do begin
            @(posedge clk);
            edges++;
            if (mem_req) begin
                saw_req = 1'b1;
                checks++;
                assert (mem_addr == line_addr)
                else report_value("mem_addr_o", mem_addr, line_addr);
            end
        end while (!cpu_ready && edges < FETCH_LIMIT);
        cpu_valid <= 1'b0;
        if (!cpu_ready) begin
            timed_out("cpu_ready_o");
        end else begin
            n_access++;
            if (expect_miss) begin
                n_miss++;
            end else begin
                n_hit++;
            end
            checks += 2;
            assert (cpu_data == expected)
            else report_value("cpu_data_o", cpu_data, expected);
            assert (saw_req == expect_miss)
            else report_value("mem_req_o", 32'(saw_req), 32'(expect_miss));
            if (!expect_miss) begin
                // valid is accepted one edge after it is driven
                checks++;
                assert (edges - 1 == 2)
                else report_value("ready latency", 32'(edges - 1), 32'd2);
            end
        end
    endtask

    task automatic check_counters();
        icache_types_pkg::word_t val;
        wb_read(icache_cfg_pkg::REG_ACCESS, val);
        checks++;
        assert (val == 32'(n_access)) else report_value("REG_ACCESS", val, 32'(n_access));
        wb_read(icache_cfg_pkg::REG_MISS, val);
        checks++;
        assert (val == 32'(n_miss)) else report_value("REG_MISS", val, 32'(n_miss));
        wb_read(icache_cfg_pkg::REG_HIT, val);
        checks++;
        assert (val == 32'(n_hit)) else report_value("REG_HIT", val, 32'(n_hit));
    endtask

    task automatic clear_counters();
        wb_write(icache_cfg_pkg::REG_ACCESS, '0);
        n_access = 0;
        n_miss   = 0;
        n_hit    = 0;
    endtask

    task automatic cold_miss_then_hit();
        fetch(32'h0000_1040, 1'b1);
        fetch(32'h0000_1048, 1'b0);
        fetch(32'h0000_104c, 1'b0);
    endtask

    // index 8 for both lines with different tags
    task automatic conflicting_lines();
        for (int i = 0; i < 3; i++) begin
            fetch(32'h0000_2080, 1'b1);
            fetch(32'h0004_2084, 1'b1);
        end
    endtask

    task automatic counter_readback();
        clear_counters();
        check_counters();
        fetch(32'h0000_3000, 1'b1);
        fetch(32'h0000_3004, 1'b0);
        fetch(32'h0000_3008, 1'b0);
        fetch(32'h0000_3010, 1'b1);
        fetch(32'h0000_3014, 1'b0);
        check_counters();
        // clearing one counter zeroes all three
        clear_counters();
        check_counters();
    endtask

    task automatic invalidate_all();
        fetch(32'h0000_3004, 1'b0);
        // request invalidate with enable kept set
        wb_write(icache_cfg_pkg::REG_CTRL, 32'h3);
        fetch(32'h0000_3004, 1'b1);
        fetch(32'h0000_3000, 1'b0);
        check_counters();
    endtask

    task automatic disabled_cache();
        icache_types_pkg::word_t val;
        wb_write(icache_cfg_pkg::REG_CTRL, 32'h0);
        wb_read(icache_cfg_pkg::REG_CTRL, val);
        checks++;
        assert (val == 32'h0) else report_value("REG_CTRL", val, 32'h0);
        // no store writes so each fetch refills
        for (int i = 0; i < 3; i++) begin
            fetch(32'h0000_5008, 1'b1);
        end
        wb_write(icache_cfg_pkg::REG_CTRL, 32'h1);
        fetch(32'h0000_5008, 1'b1);
        fetch(32'h0000_500c, 1'b0);
        check_counters();
    endtask

    initial begin
        void'($urandom(32'ha8ad));
        rst_n     = 1'b0;
        cpu_valid = 1'b0;
        cpu_addr  = '0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // outputs idle and counters zero after reset
        checks++;
        assert (!cpu_ready && !mem_req && !wb_ack)
        else begin
            errors++;
            $display("handshake outputs not low after reset at %0t", $time);
        end
        check_counters();
        cold_miss_then_hit();
        conflicting_lines();
        counter_readback();
        invalidate_all();
        disabled_cache();
        finish_run();
    end

endmodule

// File: icache_top.f
verilog/icache_cfg_pkg.sv
verilog/icache_types_pkg.sv
verilog/icache_array_if.sv
verilog/icache_store.sv
verilog/icache_controller.sv
verilog/icache_regs.sv
verilog/icache_top.sv
tb/tb_clock.sv
tb/tb_icache.sv

// File: Makefile
SRCS := $(shell cat icache_top.f)

obj_dir/Vtb_icache: icache_top.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_icache -Mdir obj_dir -f icache_top.f

.PHONY: run clean

run: obj_dir/Vtb_icache
	@out="$$(./obj_dir/Vtb_icache)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
